// File: Bender.yml
package:
  name: wb_cache

sources:
  - hw/cache_pkg.sv
  - hw/cache_dpram.sv
  - hw/cache_front_fsm.sv
  - hw/line_engine.sv
  - hw/wb_cache_top.sv
  - target: test
    files:
      - dv/cache_checker.sv
      - dv/cache_monitor.sv
      - dv/cache_tb.sv

// File: dv/cache_checker.sv
// Protocol assertions for the Wishbone and FML ports of the cache.
// Attached to every wb_cache_top instance by bind. Idle during reset.
`timescale 1ns/1ps

module cache_checker (
	input logic clk,
	input logic reset,
	input logic wb_stb_i,
	input logic wb_ack_o,
	input logic fml_rd_o,
	input logic fml_wr_o,
	input logic fml_wnext_o,
	input logic fml_rnext_o
);

	// Number of assertion failures so far
	int fails = 0;

	// Ack only answers a live strobe, and lasts one cycle
	ack_needs_stb: assert property (@(posedge clk) disable iff (reset) wb_ack_o |-> wb_stb_i)
		else begin
			$error("wb_ack_o high without wb_stb_i");
			fails++;
		end
	ack_one_cycle: assert property (@(posedge clk) disable iff (reset) wb_ack_o |=> !wb_ack_o)
		else begin
			$error("wb_ack_o held for more than one cycle");
			fails++;
		end

	rd_wr_excl: assert property (@(posedge clk) disable iff (reset) !(fml_rd_o && fml_wr_o))
		else begin
			$error("fml_rd_o and fml_wr_o high together");
			fails++;
		end

	// Pops belong to a fill, pushes to a spill that ends in a write
	rnext_in_fill: assert property (@(posedge clk) disable iff (reset) fml_rnext_o |-> fml_rd_o)
		else begin
			$error("fml_rnext_o outside a fill");
			fails++;
		end
	wnext_in_spill: assert property (@(posedge clk) disable iff (reset)
		fml_wnext_o |-> (!fml_rd_o && !fml_wr_o))
		else begin
			$error("fml_wnext_o overlaps another FML transfer");
			fails++;
		end
	spill_then_wr: assert property (@(posedge clk) disable iff (reset)
		$fell(fml_wnext_o) |-> fml_wr_o)
		else begin
			$error("spill words not followed by fml_wr_o");
			fails++;
		end

endmodule

bind wb_cache_top cache_checker checker_i (
	.clk(clk),
	.reset(reset),
	.wb_stb_i(wb_stb_i),
	.wb_ack_o(wb_ack_o),
	.fml_rd_o(fml_rd_o),
	.fml_wr_o(fml_wr_o),
	.fml_wnext_o(fml_wnext_o),
	.fml_rnext_o(fml_rnext_o)
);

// File: dv/cache_monitor.sv
// Watches the cache ports at the falling edge and compares results with a
// reference of the memory as Wishbone sees it. Untouched words hold their
// address XOR A5A5A5A5. Spilled lines are checked against the same reference.
`timescale 1ns/1ps

module cache_monitor #(
	parameter int SET_BITS = 7,
	parameter int TAG_BITS = 16
) (
	input logic                         clk,
	input logic [TAG_BITS+SET_BITS+3:0] wb_adr_i,
	input cache_pkg::wb_dat_t           wb_dat_i,
	input cache_pkg::wb_sel_t           wb_sel_i,
	input logic                         wb_we_i,
	input cache_pkg::wb_dat_t           wb_dat_o,
	input logic                         wb_ack_o,
	input logic                         fml_rd_o,
	input logic [TAG_BITS+SET_BITS-1:0] fml_adr_o,
	input cache_pkg::wb_dat_t           fml_wdat_o,
	input logic                         fml_wnext_o
);

	import cache_pkg::*;

	wb_dat_t ref_mem [logic [31:0]];
	wb_dat_t spill_q [$];
	bit      wdat_due = 0;

	string   cur_name;
	bit      cur_exp_valid;
	wb_dat_t cur_exp;
	int      cur_mode;
	bit      active = 0;
	int      cycles;
	bit      saw_fill;
	int      spills = 0;
	int      spills_at_start;
	int      test_errs;

	int err_cnt = 0;
	int test_cnt = 0;
	int failed_tests = 0;

	function automatic wb_dat_t ref_word(input logic [31:0] a);
		if (ref_mem.exists(a))
			return ref_mem[a];
		return a ^ 32'hA5A5A5A5;
	endfunction

	// Mode 1 expects a hit, mode 2 expects a line spill during the request
	task automatic begin_test(input string name, input bit exp_valid, input wb_dat_t exp,
			input int mode);
		cur_name        = name;
		cur_exp_valid   = exp_valid;
		cur_exp         = exp;
		cur_mode        = mode;
		cycles          = 0;
		saw_fill        = 0;
		spills_at_start = spills;
		test_errs       = 0;
		active          = 1;
	endtask

	task automatic compare(input string what, input wb_dat_t exp, input wb_dat_t act);
		if (exp !== act) begin
			$display("MISMATCH %s %s expected %h actual %h", cur_name, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_spill();
		logic [31:0] base;
		base = 32'({fml_adr_o, 4'b0000});
		for (int w = 0; w < 4; w++)
			compare($sformatf("spill word %h", base + 4 * w), ref_word(base + 4 * w),
				spill_q[w]);
		spill_q.delete();
		spills++;
	endtask

	task automatic finish_test();
		logic [31:0] a;
		wb_dat_t     v;
		a = 32'(wb_adr_i) & ~32'h3;
		active = 0;
		if (wb_we_i) begin
			v = ref_word(a);
			for (int i = 0; i < 4; i++)
				if (wb_sel_i[i])
					v[8*i +: 8] = wb_dat_i[8*i +: 8];
			ref_mem[a] = v;
		end else begin
			compare("read vs reference", ref_word(a), wb_dat_o);
			if (cur_exp_valid)
				compare("read vs vector", cur_exp, wb_dat_o);
		end
		if (cur_mode == 1 && cycles != 2) begin
			$display("MISMATCH %s ack latency expected 2 actual %0d", cur_name, cycles);
			test_errs++;
		end
		if (cur_mode == 1 && saw_fill) begin
			$display("%s: a hit started a line fill on FML", cur_name);
			test_errs++;
		end
		if (cur_mode == 2 && spills == spills_at_start) begin
			$display("%s: no line spill was seen on FML", cur_name);
			test_errs++;
		end
		test_cnt++;
		err_cnt += test_errs;
		if (test_errs != 0)
			failed_tests++;
		$display("%-10s %s  %0d cycles  %0d errors", cur_name, wb_we_i ? "W" : "R", cycles,
			test_errs);
	endtask

	always @(negedge clk) begin
		// Spill data trails each wnext pulse by one cycle
		if (wdat_due) begin
			spill_q.push_back(fml_wdat_o);
			if (spill_q.size() == 4)
				check_spill();
		end
		wdat_due = fml_wnext_o;
		if (active) begin
			cycles++;
			if (fml_rd_o)
				saw_fill = 1;
			if (wb_ack_o)
				finish_test();
		end
	end

endmodule

// File: dv/cache_tb.sv
// Testbench for the Wishbone cache. Requests come from dv/cache_vectors.txt,
// run from the project root. An FML memory model with random delays serves
// fills and spills; untouched memory words hold their address XOR A5A5A5A5.
`timescale 1ns/1ps

module cache_tb;

	import cache_pkg::*;

	localparam int SET_BITS = SET_BITS_DEF;
	localparam int TAG_BITS = TAG_BITS_DEF;
	localparam int ADR_W    = TAG_BITS + SET_BITS + 4;
	localparam int ACK_TIMEOUT = 2000;

	logic                         clk = 0;
	logic                         reset;
	logic [ADR_W-1:0]             wb_adr_i;
	wb_dat_t                      wb_dat_i;
	wb_sel_t                      wb_sel_i;
	logic                         wb_cyc_i;
	logic                         wb_stb_i;
	logic                         wb_we_i;
	wb_dat_t                      wb_dat_o;
	logic                         wb_ack_o;
	logic                         fml_rd_o;
	logic                         fml_wr_o;
	logic [TAG_BITS+SET_BITS-1:0] fml_adr_o;
	wb_dat_t                      fml_wdat_o;
	logic                         fml_wnext_o;
	logic                         fml_done_i;
	logic                         fml_rempty_i;
	wb_dat_t                      fml_rdat_i;
	logic                         fml_rnext_o;

	wb_dat_t     mem [logic [31:0]];
	wb_dat_t     spill_q [$];
	bit          wdat_due = 0;
	logic [31:0] rng = 32'h7d931973;
	int          tb_errs = 0;
	bit          timed_out = 0;

	always #5 clk = ~clk;

	wb_cache_top #(.SET_BITS(SET_BITS), .TAG_BITS(TAG_BITS)) wb_cache_top_i (.*);

	cache_monitor #(.SET_BITS(SET_BITS), .TAG_BITS(TAG_BITS)) monitor_i (
		.clk(clk), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
		.wb_we_i(wb_we_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .fml_rd_o(fml_rd_o),
		.fml_adr_o(fml_adr_o), .fml_wdat_o(fml_wdat_o), .fml_wnext_o(fml_wnext_o)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic wb_dat_t mem_word(input logic [31:0] a);
		if (mem.exists(a))
			return mem[a];
		return a ^ 32'hA5A5A5A5;
	endfunction

	// ------------------------------------------------------------------------
	// FML memory model
	// ------------------------------------------------------------------------
	always @(negedge clk) begin
		if (wdat_due)
			spill_q.push_back(fml_wdat_o);
		wdat_due = fml_wnext_o;
	end

	task automatic serve_fill();
		logic [31:0] base;
		base = 32'({fml_adr_o, 4'b0000});
		for (int w = 0; w < 4; w++) begin
			rng = xorshift(rng);
			repeat (rng % 3) begin
				fml_rempty_i = 1'b1;
				@(posedge clk);
				#1;
			end
			fml_rempty_i = 1'b0;
			fml_rdat_i   = mem_word(base + 4 * w);
			// The engine must pop every word it is offered
			@(negedge clk);
			if (!fml_rnext_o) begin
				$display("fill word %0d of line %h was not popped", w, base);
				tb_errs++;
			end
			@(posedge clk);
			#1;
		end
		fml_rempty_i = 1'b1;
		fml_done_i   = 1'b1;
		@(posedge clk);
		#1;
		fml_done_i = 1'b0;
	endtask

	task automatic finish_spill();
		logic [31:0] base;
		base = 32'({fml_adr_o, 4'b0000});
		rng = xorshift(rng);
		repeat (rng % 4 + 1) begin
			@(posedge clk);
			#1;
		end
		if (spill_q.size() != 4) begin
			$display("spill of line %h carried %0d words", base, spill_q.size());
			tb_errs++;
		end
		for (int w = 0; w < 4 && w < spill_q.size(); w++)
			mem[base + 4 * w] = spill_q[w];
		spill_q.delete();
		fml_done_i = 1'b1;
		@(posedge clk);
		#1;
		fml_done_i = 1'b0;
	endtask

	initial begin
		forever begin
			@(posedge clk);
			#1;
			if (!reset && fml_rd_o)
				serve_fill();
			else if (!reset && fml_wr_o)
				finish_spill();
		end
	end

	// ------------------------------------------------------------------------
	// Wishbone driver
	// ------------------------------------------------------------------------
	task automatic run_request(input string name, input string op, input logic [31:0] adr,
			input wb_dat_t dat, input wb_sel_t sel, input wb_dat_t exp, input int mode);
		int cycles;
		@(posedge clk);
		#1;
		monitor_i.begin_test(name, op == "R", exp, mode);
		wb_adr_i = adr[ADR_W-1:0];
		wb_dat_i = dat;
		wb_sel_i = sel;
		wb_we_i  = (op == "W");
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		cycles   = 0;
		while (!wb_ack_o && cycles < ACK_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!wb_ack_o) begin
			$display("%s: no ack within %0d cycles", name, ACK_TIMEOUT);
			tb_errs++;
			timed_out = 1;
		end else begin
			@(posedge clk);
			#1;
			wb_cyc_i = 1'b0;
			wb_stb_i = 1'b0;
			wb_we_i  = 1'b0;
		end
	endtask

	initial begin
		int          fd;
		int          n;
		int          mode;
		string       line;
		string       name;
		string       op;
		logic [31:0] adr;
		wb_dat_t     dat;
		wb_sel_t     sel;
		wb_dat_t     exp;
		reset        = 1'b1;
		wb_adr_i     = '0;
		wb_dat_i     = '0;
		wb_sel_i     = '0;
		wb_cyc_i     = 1'b0;
		wb_stb_i     = 1'b0;
		wb_we_i      = 1'b0;
		fml_done_i   = 1'b0;
		fml_rempty_i = 1'b1;
		fml_rdat_i   = '0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		// Tag clear runs with the bus quiet
		repeat ((1 << SET_BITS) + 2) begin
			@(negedge clk);
			if (wb_ack_o || fml_rd_o || fml_wr_o) begin
				$display("bus activity during the tag clear after reset");
				tb_errs++;
			end
		end

		fd = $fopen("dv/cache_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open dv/cache_vectors.txt");
			tb_errs++;
		end else begin
			while (!$feof(fd) && !timed_out) begin
				line = "";
				n = $fgets(line, fd);
				if (line.len() < 2 || line[0] == "#")
					continue;
				n = $sscanf(line, "%s %s %h %h %h %h %d", name, op, adr, dat, sel, exp, mode);
				if (n != 7) begin
					$display("malformed vector line: %s", line);
					tb_errs++;
				end else begin
					run_request(name, op, adr, dat, sel, exp, mode);
				end
			end
			$fclose(fd);
		end

		repeat (10) @(posedge clk);
		$display("%0d tests, %0d failed, %0d check errors, %0d assert errors, %0d other errors",
			monitor_i.test_cnt, monitor_i.failed_tests, monitor_i.err_cnt,
			wb_cache_top_i.checker_i.fails, tb_errs);
		if (monitor_i.err_cnt == 0 && tb_errs == 0 && wb_cache_top_i.checker_i.fails == 0 &&
				!timed_out && monitor_i.test_cnt > 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: dv/cache_vectors.txt
# name op byte_address data sel expected_read mode
# mode 0 any path, 1 hit with 2-cycle ack and no fill, 2 line spill expected
r_a0     R 00000850 00000000 f a5a5adf5 0
w_a0     W 00000850 11223344 3 00000000 1
r_a0b    R 00000850 00000000 f a5a53344 1
r_b0     R 00001050 00000000 f a5a5b5f5 0
r_a1     R 00000854 00000000 f a5a5adf1 1
r_b0b    R 00001050 00000000 f a5a5b5f5 1
w_c0     W 00001850 cafebabe f 00000000 2
r_c0     R 00001850 00000000 f cafebabe 1
r_a0c    R 00000850 00000000 f a5a53344 0
r_a1b    R 00000854 00000000 f a5a5adf1 1
r_b0c    R 00001050 00000000 f a5a5b5f5 2
r_c0b    R 00001850 00000000 f cafebabe 0
w_d1     W 00000124 00aa0000 4 00000000 0
r_d1     R 00000124 00000000 f a5aaa481 1
r_d0     R 00000120 00000000 f a5a5a485 1

// File: flist.f
hw/cache_pkg.sv
hw/cache_dpram.sv
hw/cache_front_fsm.sv
hw/line_engine.sv
hw/wb_cache_top.sv
dv/cache_checker.sv
dv/cache_monitor.sv
dv/cache_tb.sv

// File: hw/cache_dpram.sv
// Two-port RAM with a registered read on each port. It has no reset.
// A read during a write to the same address returns the old content.
// Both ports must never write one address in the same cycle.
`timescale 1ns/1ps

module cache_dpram #(
	parameter int ADR_BITS = 7,
	parameter int DAT_W    = 32
) (
	input  logic                clk,
	input  logic [ADR_BITS-1:0] adr0_i,
	input  logic [DAT_W-1:0]    din0_i,
	input  logic                we0_i,
	output logic [DAT_W-1:0]    dout0_o,
	input  logic [ADR_BITS-1:0] adr1_i,
	input  logic [DAT_W-1:0]    din1_i,
	input  logic                we1_i,
	output logic [DAT_W-1:0]    dout1_o
);

	logic [DAT_W-1:0] mem [2**ADR_BITS];

	always_ff @(posedge clk) begin
		if (we0_i)
			mem[adr0_i] <= din0_i;
		if (we1_i)
			mem[adr1_i] <= din1_i;
		dout0_o <= mem[adr0_i];
		dout1_o <= mem[adr1_i];
	end

endmodule

// File: hw/cache_front_fsm.sv
// Wishbone side of the cache. The RAM port 0 addresses come straight from
// wb_adr_i, so the master must hold the address until wb_ack_o.
// A miss hands the line to the load/store engine and the request is
// replayed from IDLE once the line is in place.
`timescale 1ns/1ps

module cache_front_fsm #(
	parameter int SET_BITS = 7,
	parameter int TAG_BITS = 16
) (
	input  logic                                       clk,
	input  logic                                       reset,
	// Wishbone slave
	input  logic [TAG_BITS+SET_BITS+cache_pkg::WORD_BITS+1:0] wb_adr_i,
	input  cache_pkg::wb_dat_t                         wb_dat_i,
	input  cache_pkg::wb_sel_t                         wb_sel_i,
	input  logic                                       wb_cyc_i,
	input  logic                                       wb_stb_i,
	input  logic                                       wb_we_i,
	output cache_pkg::wb_dat_t                         wb_dat_o,
	output logic                                       wb_ack_o,
	// Tag RAM port 0
	input  logic [2*TAG_BITS+cache_pkg::FLAG_BITS-1:0] tag_rd_i,
	output logic [2*TAG_BITS+cache_pkg::FLAG_BITS-1:0] tag_wr_o,
	output logic                                       tag_we_o,
	// Way RAMs port 0
	input  cache_pkg::wb_dat_t                         way0_rd_i,
	input  cache_pkg::wb_dat_t                         way1_rd_i,
	output cache_pkg::wb_dat_t                         way_wr_o,
	output logic                                       way0_we_o,
	output logic                                       way1_we_o,
	// Load/store engine requests
	output logic                                       spill_req_o,
	output logic                                       fill_req_o,
	output logic                                       victim_way_o,
	output logic [TAG_BITS-1:0]                        line_tag_o,
	output logic [SET_BITS-1:0]                        line_set_o,
	input  logic                                       ls_busy_i
);

	import cache_pkg::*;

	localparam int FLAG_LSB = 2 * TAG_BITS;

	front_state_t state;

	logic [TAG_BITS-1:0] req_tag;
	logic [SET_BITS-1:0] req_set;
	logic [TAG_BITS-1:0] tag0;
	logic [TAG_BITS-1:0] tag1;
	logic                hit0;
	logic                hit1;
	logic                hit;
	logic                access;
	logic                victim_dirty;
	logic [TAG_BITS-1:0] victim_tag;
	wb_dat_t             hit_dat;

	assign req_tag = wb_adr_i[TAG_BITS+SET_BITS+WORD_BITS+1 -: TAG_BITS];
	assign req_set = wb_adr_i[SET_BITS+WORD_BITS+1 : WORD_BITS+2];

	// ------------------------------------------------------------------------
	// Hit detection on the registered tag entry
	// ------------------------------------------------------------------------
	assign tag0 = tag_rd_i[TAG_BITS-1:0];
	assign tag1 = tag_rd_i[2*TAG_BITS-1:TAG_BITS];
	assign hit0 = tag_rd_i[FLAG_LSB+F_VALID0] && (tag0 == req_tag);
	assign hit1 = tag_rd_i[FLAG_LSB+F_VALID1] && (tag1 == req_tag);
	assign hit  = hit0 || hit1;

	assign access  = (state == READ) || (state == WRITE);
	assign hit_dat = hit0 ? way0_rd_i : way1_rd_i;

	// Victim is the LRU way; only a valid dirty line needs a spill
	assign victim_tag   = tag_rd_i[FLAG_LSB+F_LRU] ? tag1 : tag0;
	assign victim_dirty = tag_rd_i[FLAG_LSB+F_LRU] ?
		(tag_rd_i[FLAG_LSB+F_VALID1] && tag_rd_i[FLAG_LSB+F_DIRTY1]) :
		(tag_rd_i[FLAG_LSB+F_VALID0] && tag_rd_i[FLAG_LSB+F_DIRTY0]);

	// ------------------------------------------------------------------------
	// Response and RAM updates
	// ------------------------------------------------------------------------
	assign wb_ack_o  = access && hit;
	assign wb_dat_o  = ((state == READ) && hit) ? hit_dat : '0;
	assign tag_we_o  = access && hit;
	assign way0_we_o = (state == WRITE) && hit0;
	assign way1_we_o = (state == WRITE) && hit1;

	// Byte merge of the write into the stored word
	always_comb begin
		way_wr_o = hit_dat;
		for (int i = 0; i < $bits(wb_sel_t); i++) begin
			if (wb_sel_i[i])
				way_wr_o[8*i +: 8] = wb_dat_i[8*i +: 8];
		end
	end

	always_comb begin
		tag_wr_o = tag_rd_i;
		// Point LRU at the way that was not touched
		tag_wr_o[FLAG_LSB+F_LRU] = hit0;
		if (state == WRITE) begin
			if (hit0)
				tag_wr_o[FLAG_LSB+F_DIRTY0] = 1'b1;
			else
				tag_wr_o[FLAG_LSB+F_DIRTY1] = 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// Request FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= IDLE;
			spill_req_o <= 1'b0;
			fill_req_o  <= 1'b0;
		end else begin
			spill_req_o <= 1'b0;
			fill_req_o  <= 1'b0;
			case (state)
				IDLE: begin
					if (wb_cyc_i && wb_stb_i && !ls_busy_i)
						state <= wb_we_i ? WRITE : READ;
				end
				READ, WRITE: begin
					if (hit) begin
						state <= IDLE;
					end else if (victim_dirty) begin
						spill_req_o <= 1'b1;
						state       <= SPILL_WAIT;
					end else begin
						fill_req_o <= 1'b1;
						state      <= FILL_WAIT;
					end
				end
				SPILL_WAIT: begin
					if (!ls_busy_i) begin
						fill_req_o <= 1'b1;
						state      <= FILL_WAIT;
					end
				end
				FILL_WAIT: begin
					// Back to IDLE, the held request then hits
					if (!ls_busy_i)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Line address and victim travel with the request pulses
	always_ff @(posedge clk) begin
		if (access && !hit) begin
			victim_way_o <= tag_rd_i[FLAG_LSB+F_LRU];
			line_set_o   <= req_set;
			line_tag_o   <= victim_dirty ? victim_tag : req_tag;
		end else if ((state == SPILL_WAIT) && !ls_busy_i) begin
			line_tag_o <= req_tag;
		end
	end

endmodule

// File: hw/cache_pkg.sv
// Shared widths, vector types and FSM encodings for the Wishbone cache.
// A cache line holds four words. Set and tag widths are module parameters.
// Each tag entry has the layout {flags, tag1, tag0}, with the flag bits at the top.

package cache_pkg;

	// ------------------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------------------
	parameter int DAT_BITS = 32;
	localparam int WORD_BITS = 2;

	// Defaults for the top-level geometry
	localparam int SET_BITS_DEF = 7;
	localparam int TAG_BITS_DEF = 16;

	// Flag field above the two tags in a tag entry
	localparam int FLAG_BITS = 5;
	localparam int F_VALID0  = 0;
	localparam int F_VALID1  = 1;
	localparam int F_DIRTY0  = 2;
	localparam int F_DIRTY1  = 3;
	// LRU bit names the way to evict next
	localparam int F_LRU     = 4;

	// ------------------------------------------------------------------------
	// Types
	// ------------------------------------------------------------------------
	typedef logic [DAT_BITS-1:0]  wb_dat_t;
	typedef logic [3:0]           wb_sel_t;
	typedef logic [WORD_BITS-1:0] word_idx_t;

	typedef enum logic [2:0] {
		IDLE,
		READ,
		WRITE,
		SPILL_WAIT,
		FILL_WAIT
	} front_state_t;

	typedef enum logic [2:0] {
		L_INIT,
		L_IDLE,
		L_SPILL,
		L_WAITDONE,
		L_FILL
	} ls_state_t;

endpackage

// File: hw/line_engine.sv
// Load/store engine: clears the tag RAM after reset, then spills and fills
// whole lines over FML through port 1 of the RAMs.
// ls_busy_o stays high while fml_rd_o waits for fml_done_i.
// The engine waits without limit on a stalled memory.
`timescale 1ns/1ps

module line_engine #(
	parameter int SET_BITS = 7,
	parameter int TAG_BITS = 16
) (
	input  logic                                       clk,
	input  logic                                       reset,
	// Front FSM
	input  logic                                       spill_req_i,
	input  logic                                       fill_req_i,
	input  logic                                       victim_way_i,
	input  logic [TAG_BITS-1:0]                        line_tag_i,
	input  logic [SET_BITS-1:0]                        line_set_i,
	output logic                                       ls_busy_o,
	// Tag RAM port 1
	output logic [SET_BITS-1:0]                        tag_adr_o,
	input  logic [2*TAG_BITS+cache_pkg::FLAG_BITS-1:0] tag_rd_i,
	output logic [2*TAG_BITS+cache_pkg::FLAG_BITS-1:0] tag_wr_o,
	output logic                                       tag_we_o,
	// Way RAMs port 1
	output logic [SET_BITS+cache_pkg::WORD_BITS-1:0]   way_adr_o,
	input  cache_pkg::wb_dat_t                         way0_rd_i,
	input  cache_pkg::wb_dat_t                         way1_rd_i,
	output cache_pkg::wb_dat_t                         way_wr_o,
	output logic                                       way0_we_o,
	output logic                                       way1_we_o,
	// FML
	output logic                                       fml_rd_o,
	output logic                                       fml_wr_o,
	output logic [TAG_BITS+SET_BITS-1:0]               fml_adr_o,
	output cache_pkg::wb_dat_t                         fml_wdat_o,
	output logic                                       fml_wnext_o,
	input  logic                                       fml_done_i,
	input  logic                                       fml_rempty_i,
	input  cache_pkg::wb_dat_t                         fml_rdat_i,
	output logic                                       fml_rnext_o
);

	import cache_pkg::*;

	localparam int FLAG_LSB = 2 * TAG_BITS;

	ls_state_t           state;
	logic                way;
	logic [TAG_BITS-1:0] adr_tag;
	// Doubles as the clear counter in L_INIT
	logic [SET_BITS-1:0] adr_set;
	word_idx_t           word;
	logic                pop;

	assign pop       = (state == L_FILL) && !fml_rempty_i;
	assign ls_busy_o = (state != L_IDLE) || fml_rd_o || spill_req_i || fill_req_i;

	assign tag_adr_o   = adr_set;
	assign way_adr_o   = {adr_set, word};
	assign fml_adr_o   = {adr_tag, adr_set};
	assign fml_wdat_o  = way ? way1_rd_i : way0_rd_i;
	assign fml_wnext_o = (state == L_SPILL);
	assign fml_rnext_o = pop;
	assign way_wr_o    = fml_rdat_i;
	assign way0_we_o   = pop && !way;
	assign way1_we_o   = pop && way;
	assign tag_we_o    = (state == L_INIT) ||
		((state == L_WAITDONE) && fml_done_i) ||
		(pop && (word == 2'd3));

	// ------------------------------------------------------------------------
	// Tag entry update
	// ------------------------------------------------------------------------
	always_comb begin
		tag_wr_o = tag_rd_i;
		case (state)
			L_INIT: tag_wr_o = '0;
			L_WAITDONE: tag_wr_o[FLAG_LSB+F_DIRTY0+way] = 1'b0;
			L_FILL: begin
				if (way)
					tag_wr_o[2*TAG_BITS-1:TAG_BITS] = adr_tag;
				else
					tag_wr_o[TAG_BITS-1:0] = adr_tag;
				tag_wr_o[FLAG_LSB+F_VALID0+way] = 1'b1;
				tag_wr_o[FLAG_LSB+F_DIRTY0+way] = 1'b0;
			end
			default: tag_wr_o = tag_rd_i;
		endcase
	end

	// ------------------------------------------------------------------------
	// Engine FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= L_INIT;
			adr_set  <= '0;
			word     <= '0;
			fml_rd_o <= 1'b0;
			fml_wr_o <= 1'b0;
		end else begin
			// Done may arrive before or after the last fill word
			if (fml_done_i)
				fml_rd_o <= 1'b0;
			case (state)
				L_INIT: begin
					adr_set <= adr_set + 1'b1;
					if (adr_set == '1)
						state <= L_IDLE;
				end
				L_IDLE: begin
					word <= '0;
					if (spill_req_i) begin
						adr_set <= line_set_i;
						state   <= L_SPILL;
					end else if (fill_req_i) begin
						adr_set  <= line_set_i;
						fml_rd_o <= 1'b1;
						state    <= L_FILL;
					end
				end
				L_SPILL: begin
					word <= word + 1'b1;
					if (word == 2'd3) begin
						fml_wr_o <= 1'b1;
						state    <= L_WAITDONE;
					end
				end
				L_WAITDONE: begin
					if (fml_done_i) begin
						fml_wr_o <= 1'b0;
						state    <= L_IDLE;
					end
				end
				L_FILL: begin
					if (pop) begin
						word <= word + 1'b1;
						if (word == 2'd3)
							state <= L_IDLE;
					end
				end
				default: state <= L_IDLE;
			endcase
		end
	end

	// Line identity, latched with each request
	always_ff @(posedge clk) begin
		if ((state == L_IDLE) && (spill_req_i || fill_req_i)) begin
			way     <= victim_way_i;
			adr_tag <= line_tag_i;
		end
	end

endmodule

// File: hw/wb_cache_top.sv
// Two-way set-associative write-back cache with a Wishbone slave port and
// an FML master port. Lines are four words. fml_adr_o is a line address.
// No request is acknowledged while the tag RAM is cleared after reset.
`timescale 1ns/1ps

module wb_cache_top #(
	parameter int SET_BITS = cache_pkg::SET_BITS_DEF,
	parameter int TAG_BITS = cache_pkg::TAG_BITS_DEF
) (
	input  logic                                             clk,
	input  logic                                             reset,
	// Wishbone slave
	input  logic [TAG_BITS+SET_BITS+cache_pkg::WORD_BITS+1:0] wb_adr_i,
	input  cache_pkg::wb_dat_t                               wb_dat_i,
	input  cache_pkg::wb_sel_t                               wb_sel_i,
	input  logic                                             wb_cyc_i,
	input  logic                                             wb_stb_i,
	input  logic                                             wb_we_i,
	output cache_pkg::wb_dat_t                               wb_dat_o,
	output logic                                             wb_ack_o,
	// FML master
	output logic                                             fml_rd_o,
	output logic                                             fml_wr_o,
	output logic [TAG_BITS+SET_BITS-1:0]                     fml_adr_o,
	output cache_pkg::wb_dat_t                               fml_wdat_o,
	output logic                                             fml_wnext_o,
	input  logic                                             fml_done_i,
	input  logic                                             fml_rempty_i,
	input  cache_pkg::wb_dat_t                               fml_rdat_i,
	output logic                                             fml_rnext_o
);

	import cache_pkg::*;

	localparam int TAG_W = 2 * TAG_BITS + FLAG_BITS;
	localparam int WAY_ADR_BITS = SET_BITS + WORD_BITS;

	// Port 0 belongs to the front FSM, port 1 to the engine
	logic [TAG_W-1:0]        tag_rd0;
	logic [TAG_W-1:0]        tag_wr0;
	logic                    tag_we0;
	logic [SET_BITS-1:0]     tag_adr1;
	logic [TAG_W-1:0]        tag_rd1;
	logic [TAG_W-1:0]        tag_wr1;
	logic                    tag_we1;
	wb_dat_t                 way0_rd0;
	wb_dat_t                 way1_rd0;
	wb_dat_t                 way_wr0;
	logic                    way0_we0;
	logic                    way1_we0;
	logic [WAY_ADR_BITS-1:0] way_adr1;
	wb_dat_t                 way0_rd1;
	wb_dat_t                 way1_rd1;
	wb_dat_t                 way_wr1;
	logic                    way0_we1;
	logic                    way1_we1;
	logic                    spill_req;
	logic                    fill_req;
	logic                    victim_way;
	logic [TAG_BITS-1:0]     line_tag;
	logic [SET_BITS-1:0]     line_set;
	logic                    ls_busy;

	cache_front_fsm #(
		.SET_BITS(SET_BITS),
		.TAG_BITS(TAG_BITS)
	) front_i (
		.clk(clk), .reset(reset),
		.wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
		.wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
		.tag_rd_i(tag_rd0), .tag_wr_o(tag_wr0), .tag_we_o(tag_we0),
		.way0_rd_i(way0_rd0), .way1_rd_i(way1_rd0), .way_wr_o(way_wr0),
		.way0_we_o(way0_we0), .way1_we_o(way1_we0),
		.spill_req_o(spill_req), .fill_req_o(fill_req), .victim_way_o(victim_way),
		.line_tag_o(line_tag), .line_set_o(line_set), .ls_busy_i(ls_busy)
	);

	line_engine #(
		.SET_BITS(SET_BITS),
		.TAG_BITS(TAG_BITS)
	) engine_i (
		.clk(clk), .reset(reset),
		.spill_req_i(spill_req), .fill_req_i(fill_req), .victim_way_i(victim_way),
		.line_tag_i(line_tag), .line_set_i(line_set), .ls_busy_o(ls_busy),
		.tag_adr_o(tag_adr1), .tag_rd_i(tag_rd1), .tag_wr_o(tag_wr1), .tag_we_o(tag_we1),
		.way_adr_o(way_adr1), .way0_rd_i(way0_rd1), .way1_rd_i(way1_rd1),
		.way_wr_o(way_wr1), .way0_we_o(way0_we1), .way1_we_o(way1_we1),
		.fml_rd_o(fml_rd_o), .fml_wr_o(fml_wr_o), .fml_adr_o(fml_adr_o),
		.fml_wdat_o(fml_wdat_o), .fml_wnext_o(fml_wnext_o), .fml_done_i(fml_done_i),
		.fml_rempty_i(fml_rempty_i), .fml_rdat_i(fml_rdat_i), .fml_rnext_o(fml_rnext_o)
	);

	// ------------------------------------------------------------------------
	// Tag store and the two data ways
	// ------------------------------------------------------------------------
	cache_dpram #(.ADR_BITS(SET_BITS), .DAT_W(TAG_W)) tag_ram_i (
		.clk(clk),
		.adr0_i(wb_adr_i[WAY_ADR_BITS+1:WORD_BITS+2]), .din0_i(tag_wr0),
		.we0_i(tag_we0), .dout0_o(tag_rd0),
		.adr1_i(tag_adr1), .din1_i(tag_wr1), .we1_i(tag_we1), .dout1_o(tag_rd1)
	);

	cache_dpram #(.ADR_BITS(WAY_ADR_BITS), .DAT_W(DAT_BITS)) way0_ram_i (
		.clk(clk),
		.adr0_i(wb_adr_i[WAY_ADR_BITS+1:2]), .din0_i(way_wr0),
		.we0_i(way0_we0), .dout0_o(way0_rd0),
		.adr1_i(way_adr1), .din1_i(way_wr1), .we1_i(way0_we1), .dout1_o(way0_rd1)
	);

	cache_dpram #(.ADR_BITS(WAY_ADR_BITS), .DAT_W(DAT_BITS)) way1_ram_i (
		.clk(clk),
		.adr0_i(wb_adr_i[WAY_ADR_BITS+1:2]), .din0_i(way_wr0),
		.we0_i(way1_we0), .dout0_o(way1_rd0),
		.adr1_i(way_adr1), .din1_i(way_wr1), .we1_i(way1_we1), .dout1_o(way1_rd1)
	);

endmodule
